// File: rtl/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5

`define RESET_VECTOR 32'hBFC00000
// Fetching from here stops the core
`define HALT_ADDR 32'h00000000

`define LINK_REG 5'd31
`define V0_REG 5'd2

`endif

// File: rtl/cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

    typedef enum logic [5:0] {
        OpR     = 6'h00,
        OpJ     = 6'h02,
        OpJal   = 6'h03,
        OpBeq   = 6'h04,
        OpBne   = 6'h05,
        OpAddiu = 6'h09,
        OpSlti  = 6'h0A,
        OpSltiu = 6'h0B,
        OpAndi  = 6'h0C,
        OpOri   = 6'h0D,
        OpXori  = 6'h0E,
        OpLui   = 6'h0F,
        OpLw    = 6'h23,
        OpSw    = 6'h2B
    } opcodeT;

    typedef enum logic [5:0] {
        FnSll  = 6'h00,
        FnSrl  = 6'h02,
        FnSra  = 6'h03,
        FnSllv = 6'h04,
        FnSrlv = 6'h06,
        FnSrav = 6'h07,
        FnJr   = 6'h08,
        FnJalr = 6'h09,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnSlt  = 6'h2A,
        FnSltu = 6'h2B
    } funcT;

    typedef enum logic [2:0] {
        StFetch     = 3'd0,
        StDecode    = 3'd1,
        StExec      = 3'd2,
        StMem       = 3'd3,
        StWriteBack = 3'd4,
        StHalted    = 3'd7
    } stateT;

    typedef enum logic [3:0] {
        AluAnd, AluOr, AluAdd, AluSub, AluSlt, AluSltu, AluXor,
        AluSll, AluSrl, AluSra, AluSllv, AluSrlv, AluSrav, AluLui
    } aluOpT;

    // Selects ALU operand B
    typedef enum logic [1:0] {ImmNone, ImmZeroExt, ImmSignExt} immKindT;

    typedef enum logic [1:0] {DestRd, DestRt, DestLink} destSelT;

    typedef enum logic [2:0] {JumpNone, JumpBeq, JumpBne, JumpImm, JumpReg} jumpKindT;

    typedef struct packed {
        aluOpT    aluOp;
        immKindT  immKind;
        destSelT  destSel;
        jumpKindT jumpKind;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        // Write-back data is PC+8
        logic     link;
    } ctrlT;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0]   address;
        logic [`DATA_WIDTH-1:0]   writedata;
        logic [`DATA_WIDTH/8-1:0] byteenable;
        logic                     read;
        logic                     write;
    } busReqT;

endpackage

// File: rtl/instrDecode.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module instrDecode
    import cpuPkg::*;
(
    input  logic [`DATA_WIDTH-1:0] instr,
    output ctrlT                   ctrl
);

    opcodeT                    opcode;
    funcT                      func;
    logic [`REG_ADDR_WIDTH-1:0] rd;

    assign opcode = opcodeT'(instr[31:26]);
    assign func   = funcT'(instr[5:0]);
    assign rd     = instr[15:11];

    always_comb begin
        // Anything not matched below is a no-op
        ctrl = '{aluOp: AluAdd, immKind: ImmNone, destSel: DestRd, jumpKind: JumpNone,
                 regWrite: 1'b0, memRead: 1'b0, memWrite: 1'b0, link: 1'b0};
        case (opcode)
            OpR: begin
                ctrl.regWrite = 1'b1;
                case (func)
                    FnAddu: ctrl.aluOp = AluAdd;
                    FnSubu: ctrl.aluOp = AluSub;
                    FnAnd:  ctrl.aluOp = AluAnd;
                    FnOr:   ctrl.aluOp = AluOr;
                    FnXor:  ctrl.aluOp = AluXor;
                    FnSlt:  ctrl.aluOp = AluSlt;
                    FnSltu: ctrl.aluOp = AluSltu;
                    FnSll:  ctrl.aluOp = AluSll;
                    FnSrl:  ctrl.aluOp = AluSrl;
                    FnSra:  ctrl.aluOp = AluSra;
                    FnSllv: ctrl.aluOp = AluSllv;
                    FnSrlv: ctrl.aluOp = AluSrlv;
                    FnSrav: ctrl.aluOp = AluSrav;
                    FnJr: begin
                        ctrl.jumpKind = JumpReg;
                        ctrl.regWrite = 1'b0;
                    end
                    FnJalr: begin
                        ctrl.jumpKind = JumpReg;
                        ctrl.link     = 1'b1;
                        // rd of zero still links, into $ra
                        ctrl.destSel  = (rd == '0) ? DestLink : DestRd;
                    end
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = DestRt;
                ctrl.immKind  = ImmSignExt;
                case (opcode)
                    OpSlti:  ctrl.aluOp = AluSlt;
                    OpSltiu: ctrl.aluOp = AluSltu;
                    OpAndi:  ctrl.aluOp = AluAnd;
                    OpOri:   ctrl.aluOp = AluOr;
                    OpXori:  ctrl.aluOp = AluXor;
                    OpLui:   ctrl.aluOp = AluLui;
                    default: ctrl.aluOp = AluAdd;
                endcase
                // Logical immediates are zero extended
                if (opcode inside {OpAndi, OpOri, OpXori, OpLui}) begin
                    ctrl.immKind = ImmZeroExt;
                end
            end
            OpLw: begin
                ctrl.immKind  = ImmSignExt;
                ctrl.destSel  = DestRt;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
            end
            OpSw: begin
                ctrl.immKind  = ImmSignExt;
                ctrl.memWrite = 1'b1;
            end
            OpBeq: begin
                ctrl.aluOp    = AluSub;
                ctrl.jumpKind = JumpBeq;
            end
            OpBne: begin
                ctrl.aluOp    = AluSub;
                ctrl.jumpKind = JumpBne;
            end
            OpJ: ctrl.jumpKind = JumpImm;
            OpJal: begin
                ctrl.jumpKind = JumpImm;
                ctrl.destSel  = DestLink;
                ctrl.regWrite = 1'b1;
                ctrl.link     = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module alu
    import cpuPkg::*;
(
    input  aluOpT                  op,
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  logic [4:0]             shamt,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   zero
);

    localparam int HalfWidth = `DATA_WIDTH / 2;

    logic signedLess;
    logic unsignedLess;

    assign signedLess   = $signed(a) < $signed(b);
    assign unsignedLess = a < b;

    always_comb begin
        case (op)
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluXor:  result = a ^ b;
            AluAdd:  result = a + b;
            AluSub:  result = a - b;
            AluSlt:  result = {{(`DATA_WIDTH-1){1'b0}}, signedLess};
            AluSltu: result = {{(`DATA_WIDTH-1){1'b0}}, unsignedLess};
            // Shifts act on b, amount from shamt or a
            AluSll:  result = b << shamt;
            AluSrl:  result = b >> shamt;
            AluSra:  result = $signed(b) >>> shamt;
            AluSllv: result = b << a[4:0];
            AluSrlv: result = b >> a[4:0];
            AluSrav: result = $signed(b) >>> a[4:0];
            AluLui:  result = {b[HalfWidth-1:0], {HalfWidth{1'b0}}};
            default: result = '0;
        endcase
    end

    // Used by BEQ/BNE
    assign zero = (result == '0);

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module regFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       writeEn,
    input  logic [`REG_ADDR_WIDTH-1:0] wrAddr,
    input  logic [`DATA_WIDTH-1:0]     wrData,
    input  logic [`REG_ADDR_WIDTH-1:0] rdAddrA,
    input  logic [`REG_ADDR_WIDTH-1:0] rdAddrB,
    output logic [`DATA_WIDTH-1:0]     rdDataA,
    output logic [`DATA_WIDTH-1:0]     rdDataB,
    output logic [`DATA_WIDTH-1:0]     v0
);

    logic [`DATA_WIDTH-1:0] regs [2**`REG_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // $zero is hardwired
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

    assign v0 = regs[`V0_REG];

endmodule

// File: rtl/cpuSequencer.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpuSequencer
    import cpuPkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       waitrequest,
    input  logic [`DATA_WIDTH-1:0]     readdata,
    input  ctrlT                       ctrl,
    input  logic [`DATA_WIDTH-1:0]     rsData,
    input  logic [`DATA_WIDTH-1:0]     rtData,
    input  logic [`DATA_WIDTH-1:0]     aluResult,
    input  logic                       aluZero,
    output logic [`DATA_WIDTH-1:0]     instr,
    output logic [`DATA_WIDTH-1:0]     aluB,
    output busReqT                     busReq,
    output logic                       regWrite,
    output logic [`REG_ADDR_WIDTH-1:0] regDest,
    output logic [`DATA_WIDTH-1:0]     regData,
    output logic                       active
);

    stateT                  state;
    logic [`DATA_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] pcPlus4;
    logic [`DATA_WIDTH-1:0] pcPlus8;
    logic [`DATA_WIDTH-1:0] aluOut;
    logic [`DATA_WIDTH-1:0] immSext;
    logic [`DATA_WIDTH-1:0] branchTarget;
    // 1 = taken, 2 = delay slot in flight
    logic [1:0]             branchCnt;
    logic                   branchTaken;
    logic                   rdReq;
    logic                   wrReq;

    assign pcPlus4 = pc + 4;
    assign pcPlus8 = pc + 8;
    assign immSext = {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]};

    always_comb begin
        case (ctrl.immKind)
            ImmZeroExt: aluB = {{(`DATA_WIDTH-16){1'b0}}, instr[15:0]};
            ImmSignExt: aluB = immSext;
            default:    aluB = rtData;
        endcase
    end

    // ALU inputs are unchanged in Mem, so zero is still valid there
    assign branchTaken = (ctrl.jumpKind == JumpBeq && aluZero)
                      || (ctrl.jumpKind == JumpBne && !aluZero);

    assign rdReq = (state == StFetch && pc != `HALT_ADDR) || (state == StMem && ctrl.memRead);
    assign wrReq = state == StMem && ctrl.memWrite;

    assign busReq.address    = (state == StFetch) ? pc : aluOut;
    assign busReq.writedata  = rtData;
    assign busReq.byteenable = (rdReq || wrReq) ? '1 : '0;
    assign busReq.read       = rdReq;
    assign busReq.write      = wrReq;

    always_comb begin
        case (ctrl.destSel)
            DestRt:   regDest = instr[20:16];
            DestLink: regDest = `LINK_REG;
            default:  regDest = instr[15:11];
        endcase
    end

    assign regWrite = state == StWriteBack && ctrl.regWrite && regDest != '0;
    assign regData  = ctrl.memRead ? readdata : (ctrl.link ? pcPlus8 : aluOut);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= StFetch;
            pc        <= `RESET_VECTOR;
            active    <= 1'b1;
            branchCnt <= 2'd0;
        end else begin
            case (state)
                StFetch: begin
                    if (pc == `HALT_ADDR) begin
                        state  <= StHalted;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= StDecode;
                    end
                end
                StDecode: begin
                    instr <= readdata;
                    state <= StExec;
                end
                StExec: begin
                    aluOut <= aluResult;
                    if (ctrl.jumpKind == JumpImm) begin
                        branchCnt    <= 2'd1;
                        branchTarget <= {pcPlus4[31:28], instr[25:0], 2'b00};
                    end else if (ctrl.jumpKind == JumpReg) begin
                        branchCnt    <= 2'd1;
                        branchTarget <= rsData;
                    end
                    state <= StMem;
                end
                StMem: begin
                    if (branchTaken) begin
                        branchCnt    <= 2'd1;
                        branchTarget <= pcPlus4 + {immSext[`DATA_WIDTH-3:0], 2'b00};
                    end
                    if (!((ctrl.memRead || ctrl.memWrite) && waitrequest)) begin
                        state <= StWriteBack;
                    end
                end
                StWriteBack: begin
                    // Target is taken after the delay slot retires
                    if (branchCnt == 2'd1) begin
                        branchCnt <= 2'd2;
                        pc        <= pcPlus4;
                    end else if (branchCnt == 2'd2) begin
                        branchCnt <= 2'd0;
                        pc        <= branchTarget;
                    end else begin
                        pc <= pcPlus4;
                    end
                    state <= StFetch;
                end
                default: state <= StHalted;
            endcase
        end
    end

endmodule

// File: rtl/mipsCpuBus.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module mipsCpuBus
    import cpuPkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    output logic                     active,
    output logic [`DATA_WIDTH-1:0]   register_v0,

    // Avalon-MM master
    output logic [`DATA_WIDTH-1:0]   address,
    output logic                     write,
    output logic                     read,
    input  logic                     waitrequest,
    output logic [`DATA_WIDTH-1:0]   writedata,
    output logic [`DATA_WIDTH/8-1:0] byteenable,
    input  logic [`DATA_WIDTH-1:0]   readdata
);

    logic [`DATA_WIDTH-1:0]     instr;
    ctrlT                       ctrl;
    logic [`DATA_WIDTH-1:0]     aluB;
    logic [`DATA_WIDTH-1:0]     aluResult;
    logic                       aluZero;
    logic [`DATA_WIDTH-1:0]     rsData;
    logic [`DATA_WIDTH-1:0]     rtData;
    busReqT                     busReq;
    logic                       regWrite;
    logic [`REG_ADDR_WIDTH-1:0] regDest;
    logic [`DATA_WIDTH-1:0]     regData;

    assign address    = busReq.address;
    assign writedata  = busReq.writedata;
    assign byteenable = busReq.byteenable;
    assign read       = busReq.read;
    assign write      = busReq.write;

    cpuSequencer seqInst (
        .clk(clk), .rst(rst), .waitrequest(waitrequest), .readdata(readdata),
        .ctrl(ctrl), .rsData(rsData), .rtData(rtData),
        .aluResult(aluResult), .aluZero(aluZero),
        .instr(instr), .aluB(aluB), .busReq(busReq),
        .regWrite(regWrite), .regDest(regDest), .regData(regData),
        .active(active)
    );

    instrDecode decodeInst (
        .instr(instr), .ctrl(ctrl)
    );

    alu aluInst (
        .op(ctrl.aluOp), .a(rsData), .b(aluB), .shamt(instr[10:6]),
        .result(aluResult), .zero(aluZero)
    );

    // Read ports follow rs and rt of the held instruction
    regFile regInst (
        .clk(clk), .rst(rst),
        .writeEn(regWrite), .wrAddr(regDest), .wrData(regData),
        .rdAddrA(instr[25:21]), .rdAddrB(instr[20:16]),
        .rdDataA(rsData), .rdDataB(rtData),
        .v0(register_v0)
    );

endmodule

// File: test/avalonMemModel.sv
`timescale 1ns/1ns

module avalonMemModel #(
    parameter int MaxWaitRun = 3
) (
    input  logic        clk,
    input  logic        waitEnable,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    output logic        waitrequest,
    output logic [31:0] readdata
);

    // Sparse storage indexed by word address
    logic [31:0] words [logic [29:0]];
    logic        readPending;
    logic [29:0] readIndex;
    int          waitRun;
    int          badEnables;

    initial begin
        waitrequest = 1'b0;
        readdata    = '0;
        readPending = 1'b0;
        waitRun     = 0;
        badEnables  = 0;
    end

    function automatic logic [31:0] peekWord(logic [31:0] addr);
        // Untouched words show a pattern of their own address
        return words.exists(addr[31:2]) ? words[addr[31:2]] : addr ^ 32'h5A5A_A5A5;
    endfunction

    task automatic pokeWord(logic [31:0] addr, logic [31:0] data);
        words[addr[31:2]] = data;
    endtask

    task automatic clearAll();
        words.delete();
    endtask

    // Accept on the rising edge, waitrequest is stable here
    always @(posedge clk) begin
        readPending <= read && !waitrequest;
        readIndex   <= address[31:2];
        if ((read || write) && !waitrequest && byteenable != 4'hF) begin
            badEnables++;
        end
        if (write && !waitrequest) begin
            words[address[31:2]] = writedata;
        end
    end

    // Outputs change on the falling edge
    always @(negedge clk) begin
        if (readPending) begin
            readdata <= peekWord({readIndex, 2'b00});
        end
        if (waitEnable && waitRun < MaxWaitRun && $urandom_range(0, 1) == 1) begin
            waitrequest <= 1'b1;
            waitRun     <= waitRun + 1;
        end else begin
            waitrequest <= 1'b0;
            waitRun     <= 0;
        end
    end

endmodule

// File: test/tbMipsCpu.sv
`timescale 1ns/1ns
`include "cpu_defines.svh"

module tbMipsCpu;

    localparam int MaxWaitRun = 3;
    // Instructions executed over all five tests
    localparam int InstrCount = 2 + 20 * 8 + 23 + 15 + 14;
    localparam int RunCount = 24;
    // Accesses that can meet waitrequest in the load/store test
    localparam int WaitAccesses = 23 + 8;
    localparam int CycleLimit = 2 * (InstrCount * 5 + WaitAccesses * MaxWaitRun + RunCount * 12);

    localparam logic [4:0]  RegA = 5'd8;
    localparam logic [4:0]  RegB = 5'd9;
    localparam logic [4:0]  RegD = 5'd10;
    localparam logic [31:0] DataBase = 32'h0000_1000;

    logic        clk;
    logic        rst;
    logic        waitEnable;
    logic        active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;
    logic [31:0] progWords[$];
    int          cycles = 0;

    mipsCpuBus dut_i (
        .clk(clk), .rst(rst), .active(active), .register_v0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    avalonMemModel #(.MaxWaitRun(MaxWaitRun)) memInst (
        .clk(clk), .waitEnable(waitEnable), .address(address), .read(read),
        .write(write), .writedata(writedata), .byteenable(byteenable),
        .waitrequest(waitrequest), .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CycleLimit) begin
            $display("Timeout: the core did not halt within %0d cycles", CycleLimit);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] rType(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [4:0] sh, logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // ADDIU $v0, $v0, imm
    function automatic logic [31:0] addV0(logic [15:0] imm);
        return iType(6'h09, 5'd2, 5'd2, imm);
    endfunction

    // Instruction in the upper word and its $10 result in the lower
    function automatic logic [63:0] aluCase(int idx, logic [31:0] a, logic [31:0] b,
                                            logic [4:0] sh, logic [15:0] imm);
        logic [31:0] sx;
        logic [31:0] zx;
        sx = {{16{imm[15]}}, imm};
        zx = {16'h0000, imm};
        case (idx)
            0:  return {rType(RegA, RegB, RegD, 5'd0, 6'h21), a + b};
            1:  return {rType(RegA, RegB, RegD, 5'd0, 6'h23), a - b};
            2:  return {rType(RegA, RegB, RegD, 5'd0, 6'h24), a & b};
            3:  return {rType(RegA, RegB, RegD, 5'd0, 6'h25), a | b};
            4:  return {rType(RegA, RegB, RegD, 5'd0, 6'h26), a ^ b};
            5:  return {rType(RegA, RegB, RegD, 5'd0, 6'h2A), 32'($signed(a) < $signed(b))};
            6:  return {rType(RegA, RegB, RegD, 5'd0, 6'h2B), 32'(a < b)};
            7:  return {rType(5'd0, RegB, RegD, sh, 6'h00), b << sh};
            8:  return {rType(5'd0, RegB, RegD, sh, 6'h02), b >> sh};
            9:  return {rType(5'd0, RegB, RegD, sh, 6'h03), 32'($signed(b) >>> sh)};
            10: return {rType(RegA, RegB, RegD, 5'd0, 6'h04), b << a[4:0]};
            11: return {rType(RegA, RegB, RegD, 5'd0, 6'h06), b >> a[4:0]};
            12: return {rType(RegA, RegB, RegD, 5'd0, 6'h07), 32'($signed(b) >>> a[4:0])};
            13: return {iType(6'h09, RegA, RegD, imm), a + sx};
            14: return {iType(6'h0A, RegA, RegD, imm), 32'($signed(a) < $signed(sx))};
            15: return {iType(6'h0B, RegA, RegD, imm), 32'(a < sx)};
            16: return {iType(6'h0C, RegA, RegD, imm), a & zx};
            17: return {iType(6'h0D, RegA, RegD, imm), a | zx};
            18: return {iType(6'h0E, RegA, RegD, imm), a ^ zx};
            default: return {iType(6'h0F, 5'd0, RegD, imm), imm, 16'h0000};
        endcase
    endfunction

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            $display("sim failed");
            $fatal(1, "check on %s", name);
        end
    endtask

    // JR $zero and its delay slot
    task automatic pushHalt();
        progWords.push_back(rType(5'd0, 5'd0, 5'd0, 5'd0, 6'h08));
        progWords.push_back(32'h0000_0000);
    endtask

    task automatic loadAndReset(bit waitOn);
        @(negedge clk);
        rst = 1'b1;
        waitEnable = waitOn;
        memInst.clearAll();
        foreach (progWords[i]) begin
            memInst.pokeWord(`RESET_VECTOR + 32'(i * 4), progWords[i]);
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic waitHalt();
        while (active !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    task automatic resetHaltTest();
        progWords.delete();
        pushHalt();
        loadAndReset(1'b0);
        checkValue("active", 32'(active), 32'd1);
        checkValue("read", 32'(read), 32'd1);
        checkValue("write", 32'(write), 32'd0);
        checkValue("address", address, `RESET_VECTOR);
        checkValue("byteenable", 32'(byteenable), 32'h0000_000F);
        waitHalt();
        repeat (8) begin
            @(negedge clk);
            checkValue("active", 32'(active), 32'd0);
            checkValue("read", 32'(read), 32'd0);
            checkValue("write", 32'(write), 32'd0);
        end
        checkValue("register_v0", registerV0, 32'd0);
    endtask

    task automatic aluOpsTest();
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] pick;
        for (int idx = 0; idx < 20; idx++) begin
            a = $urandom;
            b = $urandom;
            pick = aluCase(idx, a, b, 5'($urandom), 16'($urandom));
            progWords.delete();
            progWords.push_back(iType(6'h0F, 5'd0, RegA, a[31:16]));
            progWords.push_back(iType(6'h0D, RegA, RegA, a[15:0]));
            progWords.push_back(iType(6'h0F, 5'd0, RegB, b[31:16]));
            progWords.push_back(iType(6'h0D, RegB, RegB, b[15:0]));
            progWords.push_back(pick[63:32]);
            progWords.push_back(rType(RegD, 5'd0, 5'd2, 5'd0, 6'h21));
            pushHalt();
            loadAndReset(1'b0);
            waitHalt();
            checkValue("register_v0", registerV0, pick[31:0]);
        end
    endtask

    task automatic loadStoreTest();
        logic [31:0] data [4];
        logic [31:0] sum;
        sum = '0;
        progWords.delete();
        // $16 holds the base of the data area
        progWords.push_back(iType(6'h0D, 5'd0, 5'd16, DataBase[15:0]));
        for (int k = 0; k < 4; k++) begin
            data[k] = $urandom;
            sum += data[k];
            progWords.push_back(iType(6'h0F, 5'd0, RegA, data[k][31:16]));
            progWords.push_back(iType(6'h0D, RegA, RegA, data[k][15:0]));
            progWords.push_back(iType(6'h2B, 5'd16, RegA, 16'(k * 4)));
        end
        for (int k = 0; k < 4; k++) begin
            progWords.push_back(iType(6'h23, 5'd16, RegB, 16'(k * 4)));
            progWords.push_back(rType(5'd2, RegB, 5'd2, 5'd0, 6'h21));
        end
        pushHalt();
        loadAndReset(1'b1);
        waitHalt();
        checkValue("register_v0", registerV0, sum);
        for (int k = 0; k < 4; k++) begin
            checkValue("memory word", memInst.peekWord(DataBase + 32'(k * 4)), data[k]);
        end
        checkValue("bad byteenable count", 32'(memInst.badEnables), 32'd0);
    endtask

    task automatic branchTest();
        logic [15:0] val;
        logic [5:0]  op;
        logic [4:0]  rt;
        logic        taken;
        logic [31:0] expected;
        val = 16'($urandom_range(0, 32'h7FFE));
        expected = '0;
        progWords.delete();
        progWords.push_back(iType(6'h0D, 5'd0, RegA, val));
        progWords.push_back(iType(6'h0D, 5'd0, RegB, val));
        progWords.push_back(iType(6'h0D, 5'd0, RegD, val + 16'd1));
        // BEQ equal, BNE unequal, BEQ unequal, BNE equal
        for (int g = 0; g < 4; g++) begin
            op = (g % 2 == 0) ? 6'h04 : 6'h05;
            rt = (g == 1 || g == 2) ? RegD : RegB;
            taken = (op == 6'h04) == (rt == RegB);
            // Offset of two skips the word after the delay slot
            progWords.push_back(iType(op, RegA, rt, 16'd2));
            progWords.push_back(addV0(16'(1 << (2 * g))));
            progWords.push_back(addV0(16'(2 << (2 * g))));
            expected += 32'(1 << (2 * g));
            if (!taken) begin
                expected += 32'(2 << (2 * g));
            end
        end
        pushHalt();
        loadAndReset(1'b0);
        waitHalt();
        checkValue("register_v0", registerV0, expected);
    endtask

    task automatic jumpLinkTest();
        logic [31:0] jalAddr;
        logic [31:0] jalrAddr;
        logic [31:0] sub1;
        logic [31:0] sub2;
        jalAddr  = `RESET_VECTOR;
        jalrAddr = `RESET_VECTOR + 32'd20;
        sub1     = `RESET_VECTOR + 32'd40;
        sub2     = `RESET_VECTOR + 32'd48;
        progWords.delete();
        progWords.push_back({6'h03, sub1[27:2]});
        progWords.push_back(32'h0000_0000);
        // Return point where $4 keeps the JAL link
        progWords.push_back(rType(5'd31, 5'd0, 5'd4, 5'd0, 6'h21));
        progWords.push_back(iType(6'h0F, 5'd0, 5'd16, sub2[31:16]));
        progWords.push_back(iType(6'h0D, 5'd16, 5'd16, sub2[15:0]));
        progWords.push_back(rType(5'd16, 5'd0, 5'd5, 5'd0, 6'h09));
        progWords.push_back(32'h0000_0000);
        progWords.push_back(rType(5'd5, 5'd4, 5'd2, 5'd0, 6'h21));
        pushHalt();
        // Subroutines return through $ra and $5
        progWords.push_back(rType(5'd31, 5'd0, 5'd0, 5'd0, 6'h08));
        progWords.push_back(32'h0000_0000);
        progWords.push_back(rType(5'd5, 5'd0, 5'd0, 5'd0, 6'h08));
        progWords.push_back(32'h0000_0000);
        loadAndReset(1'b0);
        waitHalt();
        checkValue("register_v0", registerV0, (jalAddr + 32'd8) + (jalrAddr + 32'd8));
    endtask

    initial begin
        void'($urandom(70831));
        rst = 1'b1;
        waitEnable = 1'b0;
        resetHaltTest();
        aluOpsTest();
        loadStoreTest();
        branchTest();
        jumpLinkTest();
        $display("sim passed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/instrDecode.sv
rtl/alu.sv
rtl/regFile.sv
rtl/cpuSequencer.sv
rtl/mipsCpuBus.sv
test/avalonMemModel.sv
test/tbMipsCpu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tbMipsCpu
FILELIST  = sources.f
OBJDIR    = obj_dir

SIM     = $(OBJDIR)/V$(TOP)
SOURCES = $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJDIR)
